// File: cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	// Output channels computed side by side
	localparam int N_LANE = 4;

	// Q8.8 fixed point for data and weights
	localparam int FRAC_BITS = 8;

	localparam int LANE_IDX_W = $clog2(N_LANE);

	// Steps of the restoring divider used by average pool
	localparam int DIV_STEPS = 32;

	typedef logic signed [15:0] data_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [7:0] count_t;
	typedef logic [29:0] addr_t;

	localparam data_t DATA_MAX = data_t'(16'h7fff);
	localparam data_t DATA_MIN = data_t'(16'h8000);

	// Same operation codes as the host register map
	typedef enum logic [2:0] {
		OP_CONV    = 3'd1,
		OP_MAXPOOL = 3'd4,
		OP_AVGPOOL = 3'd5
	} op_e;

	typedef struct packed {
		op_e    op;
		count_t len;
		addr_t  base;
	} cmd_t;

	// One window element, a data word plus one weight per channel
	typedef struct packed {
		data_t                  data;
		data_t [N_LANE-1:0]     weight;
	} elem_t;

	typedef struct packed {
		logic               valid;
		logic               first;
		logic               last;
		op_e                op;
		data_t              data;
		data_t [N_LANE-1:0] weight;
	} lane_ctl_t;

	typedef struct packed {
		logic valid;
		acc_t total;
	} lane_res_t;

	typedef struct packed {
		addr_t addr;
		data_t data;
	} wr_t;

endpackage

`default_nettype wire

// File: engine_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module engine_ctrl (
	input  wire                 clk,
	input  wire                 i_arst_n,
	input  wire                 i_cmd_valid,
	input  wire cnn_pkg::cmd_t  i_cmd,
	input  wire                 i_elem_valid,
	input  wire cnn_pkg::elem_t i_elem,
	input  wire                 i_done,
	output logic                o_busy,
	output cnn_pkg::lane_ctl_t  o_lane_ctl,
	output cnn_pkg::cmd_t       o_cmd
);

	import cnn_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		WAIT_DRAIN
	} state_e;

	state_e state;
	cmd_t   cmd_q;
	count_t cnt;
	count_t cnt_inc;

	logic   cmd_take;
	logic   elem_take;
	logic   elem_last;

	logic               ctl_valid;
	logic               ctl_first;
	logic               ctl_last;
	data_t              ctl_data;
	data_t [N_LANE-1:0] ctl_weight;

	assign cnt_inc = cnt + count_t'(1);

	// Zero length windows never start
	assign cmd_take  = (state == IDLE) && i_cmd_valid && (i_cmd.len != '0);
	assign elem_take = (state == RUN) && i_elem_valid;
	assign elem_last = (cnt_inc == cmd_q.len);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state     <= IDLE;
			cnt       <= '0;
			ctl_valid <= 1'b0;
		end else begin
			ctl_valid <= elem_take;
			case (state)
				IDLE: begin
					if (cmd_take) begin
						cnt   <= '0;
						state <= RUN;
					end
				end
				RUN: begin
					if (elem_take) begin
						cnt <= cnt_inc;
						if (elem_last)
							state <= WAIT_DRAIN;
					end
				end
				WAIT_DRAIN: begin
					if (i_done)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Command and element payload
	always_ff @(posedge clk) begin
		if (cmd_take)
			cmd_q <= i_cmd;
		if (elem_take) begin
			ctl_first  <= (cnt == '0);
			ctl_last   <= elem_last;
			ctl_data   <= i_elem.data;
			ctl_weight <= i_elem.weight;
		end
	end

	assign o_busy = (state != IDLE);
	assign o_cmd  = cmd_q;

	always_comb begin
		o_lane_ctl.valid  = ctl_valid;
		o_lane_ctl.first  = ctl_first;
		o_lane_ctl.last   = ctl_last;
		o_lane_ctl.op     = cmd_q.op;
		o_lane_ctl.data   = ctl_data;
		o_lane_ctl.weight = ctl_weight;
	end

endmodule

`default_nettype wire

// File: pe_lane.sv
`timescale 1ns/1ps
`default_nettype none

module pe_lane (
	input  wire                     clk,
	input  wire                     i_arst_n,
	input  wire cnn_pkg::lane_ctl_t i_ctl,
	input  wire cnn_pkg::data_t     i_weight,
	output cnn_pkg::lane_res_t      o_res
);

	import cnn_pkg::*;

	acc_t acc;
	acc_t acc_next;
	acc_t prod;
	acc_t data_ext;
	logic res_valid;

	// Full 32 bit Q16.16 product
	assign prod     = acc_t'(i_ctl.data) * acc_t'(i_weight);
	assign data_ext = acc_t'(i_ctl.data);

	always_comb begin
		acc_next = acc;
		case (i_ctl.op)
			OP_CONV: begin
				if (i_ctl.first)
					acc_next = prod;
				else
					acc_next = acc + prod;
			end
			OP_MAXPOOL: begin
				if (i_ctl.first || (data_ext > acc))
					acc_next = data_ext;
			end
			OP_AVGPOOL: begin
				if (i_ctl.first)
					acc_next = data_ext;
				else
					acc_next = acc + data_ext;
			end
			default: acc_next = acc;
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			res_valid <= 1'b0;
		else
			res_valid <= i_ctl.valid && i_ctl.last;
	end

	always_ff @(posedge clk) begin
		if (i_ctl.valid)
			acc <= acc_next;
	end

	// Total is ready in the cycle after the last element
	always_comb begin
		o_res.valid = res_valid;
		o_res.total = acc;
	end

endmodule

`default_nettype wire

// File: result_drain.sv
`timescale 1ns/1ps
`default_nettype none

module result_drain (
	input  wire                     clk,
	input  wire                     i_arst_n,
	input  wire cnn_pkg::cmd_t      i_cmd,
	input  wire cnn_pkg::lane_res_t i_res [cnn_pkg::N_LANE],
	output logic                    o_wr_valid,
	output cnn_pkg::wr_t            o_wr,
	output logic                    o_done
);

	import cnn_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		EMIT,
		DIVIDE
	} state_e;

	state_e                state;
	acc_t                  tot [N_LANE];
	logic [LANE_IDX_W-1:0] idx;
	logic [5:0]            div_cnt;

	logic                  res_valid;
	logic                  last_lane;
	logic                  div_end;
	logic                  wr_fire;

	acc_t                  cur;
	acc_t                  shifted;
	data_t                 sat_data;
	data_t                 div_data;

	// Divider datapath
	logic [31:0]           quo;
	logic [7:0]            rem;
	logic                  neg;
	logic [8:0]            rem_sh;
	logic [8:0]            trial;

	always_comb begin
		res_valid = 1'b0;
		for (int i = 0; i < N_LANE; i++)
			res_valid = res_valid | i_res[i].valid;
	end

	assign cur       = tot[idx];
	assign last_lane = (idx == LANE_IDX_W'(N_LANE - 1));
	assign div_end   = (div_cnt == 6'(DIV_STEPS + 1));
	assign wr_fire   = (state == EMIT) || ((state == DIVIDE) && div_end);

	// Q16.16 back to Q8.8, floor rounding then clamp
	assign shifted = cur >>> FRAC_BITS;

	always_comb begin
		if (shifted > acc_t'(DATA_MAX))
			sat_data = DATA_MAX;
		else if (shifted < acc_t'(DATA_MIN))
			sat_data = DATA_MIN;
		else
			sat_data = shifted[15:0];
	end

	assign div_data = neg ? data_t'(-quo) : data_t'(quo);

	assign rem_sh = {rem, quo[31]};
	assign trial  = rem_sh - {1'b0, i_cmd.len};

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state   <= IDLE;
			idx     <= '0;
			div_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (res_valid) begin
						idx     <= '0;
						div_cnt <= '0;
						state   <= (i_cmd.op == OP_AVGPOOL) ? DIVIDE : EMIT;
					end
				end
				EMIT: begin
					idx <= idx + 1'b1;
					if (last_lane)
						state <= IDLE;
				end
				DIVIDE: begin
					if (div_end) begin
						div_cnt <= '0;
						idx     <= idx + 1'b1;
						if (last_lane)
							state <= IDLE;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == IDLE) && res_valid) begin
			for (int i = 0; i < N_LANE; i++)
				tot[i] <= i_res[i].total;
		end
		if (state == DIVIDE) begin
			if (div_cnt == '0) begin
				// Divide the magnitude, sign goes back on at the end
				neg <= cur[31];
				quo <= cur[31] ? 32'(-cur) : 32'(cur);
				rem <= '0;
			end else if (!div_end) begin
				if (!trial[8]) begin
					rem <= trial[7:0];
					quo <= {quo[30:0], 1'b1};
				end else begin
					rem <= rem_sh[7:0];
					quo <= {quo[30:0], 1'b0};
				end
			end
		end
	end

	always_comb begin
		o_wr_valid = wr_fire;
		o_done     = wr_fire && last_lane;
		o_wr.addr  = i_cmd.base + addr_t'(idx);
		if (state == DIVIDE)
			o_wr.data = div_data;
		else if (i_cmd.op == OP_CONV)
			o_wr.data = sat_data;
		else
			o_wr.data = cur[15:0];
	end

endmodule

`default_nettype wire

// File: cnn_engine.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_engine (
	input  wire                 clk,
	input  wire                 i_arst_n,
	input  wire                 i_cmd_valid,
	input  wire cnn_pkg::cmd_t  i_cmd,
	input  wire                 i_elem_valid,
	input  wire cnn_pkg::elem_t i_elem,
	output logic                o_busy,
	output logic                o_wr_valid,
	output cnn_pkg::wr_t        o_wr,
	output logic                o_done
);

	import cnn_pkg::*;

	cmd_t      cmd_q;
	lane_ctl_t lane_ctl;
	lane_res_t lane_res [N_LANE];
	logic      drain_done;

	engine_ctrl u_ctrl (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_cmd_valid  (i_cmd_valid),
		.i_cmd        (i_cmd),
		.i_elem_valid (i_elem_valid),
		.i_elem       (i_elem),
		.i_done       (drain_done),
		.o_busy       (o_busy),
		.o_lane_ctl   (lane_ctl),
		.o_cmd        (cmd_q)
	);

	// One lane per output channel, each picks its own weight
	for (genvar g = 0; g < N_LANE; g++) begin : g_lane
		pe_lane u_lane (
			.clk      (clk),
			.i_arst_n (i_arst_n),
			.i_ctl    (lane_ctl),
			.i_weight (lane_ctl.weight[g]),
			.o_res    (lane_res[g])
		);
	end

	result_drain u_drain (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_cmd      (cmd_q),
		.i_res      (lane_res),
		.o_wr_valid (o_wr_valid),
		.o_wr       (o_wr),
		.o_done     (drain_done)
	);

	assign o_done = drain_done;

endmodule

`default_nettype wire

// File: tb_cnn_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_engine;

	import cnn_pkg::*;

	localparam int WAIT_CYCLES = 400;

	logic  clk;
	logic  i_arst_n;
	logic  i_cmd_valid;
	cmd_t  i_cmd;
	logic  i_elem_valid;
	elem_t i_elem;
	logic  o_busy;
	logic  o_wr_valid;
	wr_t   o_wr;
	logic  o_done;

	int    cyc = 0;
	int    errors;
	int    test_no;
	int    test_err;
	int    last_cyc;

	// Current window, data plus one weight per lane
	data_t d_arr [16];
	data_t w_arr [16][N_LANE];

	addr_t wa_q [$];
	data_t wd_q [$];
	int    wc_q [$];
	logic  wdone_q [$];

	cnn_engine i_dut (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_cmd_valid  (i_cmd_valid),
		.i_cmd        (i_cmd),
		.i_elem_valid (i_elem_valid),
		.i_elem       (i_elem),
		.o_busy       (o_busy),
		.o_wr_valid   (o_wr_valid),
		.o_wr         (o_wr),
		.o_done       (o_done)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// Writes are sampled mid cycle
	always @(negedge clk) begin
		if (o_wr_valid === 1'b1) begin
			wa_q.push_back(o_wr.addr);
			wd_q.push_back(o_wr.data);
			wc_q.push_back(cyc);
			wdone_q.push_back(o_done);
		end
		assert (!(o_done === 1'b1 && o_wr_valid !== 1'b1)) else begin
			$display("Done strobe seen without a write at cycle %0d", cyc);
			errors++;
		end
	end

	function automatic data_t model_lane(input op_e op, input int len, input int lane);
		longint s;
		s = 0;
		case (op)
			OP_CONV: begin
				for (int i = 0; i < len; i++)
					s += longint'(d_arr[i]) * longint'(w_arr[i][lane]);
				s = s >>> FRAC_BITS;
				if (s > 32767)
					s = 32767;
				else if (s < -32768)
					s = -32768;
			end
			OP_MAXPOOL: begin
				s = d_arr[0];
				for (int i = 1; i < len; i++)
					if (d_arr[i] > s)
						s = d_arr[i];
			end
			default: begin
				for (int i = 0; i < len; i++)
					s += longint'(d_arr[i]);
				// Integer division truncates toward zero
				s = s / len;
			end
		endcase
		return data_t'(s);
	endfunction

	task automatic step();
		@(posedge clk);
		#0.5;
	endtask

	task automatic fill_window(input int lo, input int hi);
		for (int i = 0; i < 16; i++) begin
			d_arr[i] = data_t'(lo + int'($urandom_range(hi - lo)));
			for (int l = 0; l < N_LANE; l++)
				w_arr[i][l] = data_t'(int'($urandom_range(1023)) - 512);
		end
	endtask

	task automatic clear_writes();
		wa_q.delete();
		wd_q.delete();
		wc_q.delete();
		wdone_q.delete();
	endtask

	task automatic send_cmd(input op_e op, input int len, input addr_t base);
		step();
		i_cmd_valid = 1'b1;
		i_cmd.op    = op;
		i_cmd.len   = count_t'(len);
		i_cmd.base  = base;
		step();
		i_cmd_valid = 1'b0;
	endtask

	task automatic send_elems(input int len);
		for (int i = 0; i < len; i++) begin
			step();
			i_elem_valid = 1'b1;
			i_elem.data  = d_arr[i];
			for (int l = 0; l < N_LANE; l++)
				i_elem.weight[l] = w_arr[i][l];
			last_cyc = cyc;
		end
		step();
		i_elem_valid = 1'b0;
	endtask

	task automatic wait_writes(input int n);
		int k;
		k = 0;
		while (wd_q.size() < n && k < WAIT_CYCLES) begin
			@(negedge clk);
			#0.1;
			k++;
		end
		if (wd_q.size() < n) begin
			$display("Timed out waiting for %0d writes, saw %0d", n, wd_q.size());
			errors++;
		end
	endtask

	task automatic check_writes(input op_e op, input int len, input addr_t base, input bit timing);
		data_t exp;
		wait_writes(N_LANE);
		for (int l = 0; l < N_LANE && l < wd_q.size(); l++) begin
			exp = model_lane(op, len, l);
			assert (wa_q[l] == base + addr_t'(l)) else begin
				$display("Error: o_wr.addr lane %0d got %h expected %h",
					l, wa_q[l], base + addr_t'(l));
				errors++;
			end
			assert (wd_q[l] == exp) else begin
				$display("Error: o_wr.data lane %0d got %h expected %h", l, wd_q[l], exp);
				errors++;
			end
			assert (wdone_q[l] == (l == N_LANE - 1)) else begin
				$display("Error: o_done lane %0d got %h expected %h",
					l, wdone_q[l], (l == N_LANE - 1));
				errors++;
			end
			if (timing) begin
				assert (wc_q[l] == last_cyc + 3 + l) else begin
					$display("Write of lane %0d came at cycle %0d instead of %0d",
						l, wc_q[l], last_cyc + 3 + l);
					errors++;
				end
			end
		end
	endtask

	task automatic begin_test();
		test_no++;
		test_err = errors;
		clear_writes();
	endtask

	task automatic end_test(input string name);
		$display("Test %0d %s: %s, %0d errors", test_no, name,
			(errors == test_err) ? "ok" : "failed", errors - test_err);
	endtask

	initial begin
		void'($urandom(32'ha8a4));
		errors       = 0;
		test_no      = 0;
		i_arst_n     = 1'b0;
		i_cmd_valid  = 1'b0;
		i_cmd        = '0;
		i_elem_valid = 1'b0;
		i_elem       = '0;
		repeat (5) @(posedge clk);
		#0.5;
		i_arst_n = 1'b1;

		begin_test();
		step();
		assert (o_busy == 1'b0 && o_wr_valid == 1'b0 && o_done == 1'b0) else begin
			$display("Error: o_busy %h o_wr_valid %h o_done %h after reset, expected 0",
				o_busy, o_wr_valid, o_done);
			errors++;
		end
		fill_window(-100, 100);
		send_elems(3);
		repeat (10) step();
		assert (wd_q.size() == 0) else begin
			$display("Elements sent while idle produced %0d writes", wd_q.size());
			errors++;
		end
		send_cmd(OP_CONV, 4, 30'h100);
		assert (o_busy == 1'b1) else begin
			$display("Error: o_busy got %h expected 1 after command", o_busy);
			errors++;
		end
		// Second command lands while busy
		send_cmd(OP_MAXPOOL, 4, 30'h200);
		send_elems(4);
		check_writes(OP_CONV, 4, 30'h100, 1'b1);
		// A window for the dropped command finds nothing to run
		send_elems(4);
		repeat (20) step();
		assert (wd_q.size() == N_LANE) else begin
			$display("Dropped command still produced writes, %0d in total", wd_q.size());
			errors++;
		end
		end_test("reset and idle");

		begin_test();
		fill_window(-512, 511);
		send_cmd(OP_CONV, 9, 30'h3000);
		send_elems(9);
		check_writes(OP_CONV, 9, 30'h3000, 1'b1);
		end_test("convolution");

		begin_test();
		for (int i = 0; i < 2; i++) begin
			d_arr[i] = 16'sh4000;
			w_arr[i][0] = 16'sh4000;
			w_arr[i][1] = 16'sh4000;
			w_arr[i][2] = -16'sh4000;
			w_arr[i][3] = -16'sh4000;
		end
		send_cmd(OP_CONV, 2, 30'h40);
		send_elems(2);
		check_writes(OP_CONV, 2, 30'h40, 1'b1);
		end_test("convolution saturation");

		begin_test();
		fill_window(-3000, 3000);
		send_cmd(OP_MAXPOOL, 9, 30'h1_0000);
		send_elems(9);
		check_writes(OP_MAXPOOL, 9, 30'h1_0000, 1'b1);
		end_test("max pool");

		begin_test();
		fill_window(0, 2000);
		send_cmd(OP_AVGPOOL, 9, 30'h500);
		send_elems(9);
		check_writes(OP_AVGPOOL, 9, 30'h500, 1'b0);
		clear_writes();
		fill_window(-2000, 0);
		send_cmd(OP_AVGPOOL, 9, 30'h600);
		send_elems(9);
		check_writes(OP_AVGPOOL, 9, 30'h600, 1'b0);
		end_test("average pool");

		begin_test();
		fill_window(-512, 511);
		send_cmd(OP_CONV, 5, 30'h700);
		send_elems(5);
		check_writes(OP_CONV, 5, 30'h700, 1'b1);
		// Next command goes out in the cycle after done
		clear_writes();
		fill_window(-512, 511);
		send_cmd(OP_CONV, 5, 30'h2a_0000);
		send_elems(5);
		check_writes(OP_CONV, 5, 30'h2a_0000, 1'b1);
		end_test("back to back");

		$display("Tests run: %0d, errors: %0d", test_no, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: cnn_engine.f
cnn_pkg.sv
engine_ctrl.sv
pe_lane.sv
result_drain.sv
cnn_engine.sv
tb_cnn_engine.sv

// File: Bender.yml
package:
  name: cnn_engine

sources:
  - cnn_pkg.sv
  - engine_ctrl.sv
  - pe_lane.sv
  - result_drain.sv
  - cnn_engine.sv
  - target: simulation
    files:
      - tb_cnn_engine.sv
